// File: sources.f
+incdir+sim
design/kcpu_pkg.sv
design/kcpu_alu.sv
design/kcpu_idx.sv
design/kcpu_regs.sv
design/kcpu_ctrl.sv
design/kcpu_memctrl.sv
design/kcpu.sv
sim/kcpu_tb.sv

// File: sim/kcpu_tb_model.svh
`ifndef KCPU_TB_MODEL_SVH
`define KCPU_TB_MODEL_SVH

logic [31:0] lfsr_state;
logic [15:0] prog_pc;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
endfunction

// one lfsr step for every bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v          = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

// program bytes go to both the bus memory and the model memory
function automatic void emit(input logic [7:0] val);
    mem[prog_pc]     = val;
    ref_mem[prog_pc] = val;
    prog_pc          = prog_pc + 16'd1;
endfunction

function automatic void emit_ext(input logic [7:0] opc, input logic [15:0] ea);
    emit(opc);
    emit(ea[15:8]);
    emit(ea[7:0]);
endfunction

function automatic void build_program();
    logic [7:0] off;
    prog_pc = RESET_PC;
    off     = 8'(rand_bits(3));
    emit(lda_imm);
    emit(8'(rand_bits(8)));
    emit_ext(sta_ext, 16'h3000);
    emit(ldb_imm);
    emit(8'(rand_bits(8)));
    emit_ext(stb_ext, 16'h3001);
    emit_ext(lda_ext, 16'h2000 | 16'(rand_bits(8)));
    emit_ext(ldb_ext, 16'h2100 | 16'(rand_bits(8)));
    emit_ext(sta_ext, 16'h3002);
    emit_ext(stb_ext, 16'h3003);
    emit(adda_imm);
    emit(8'(rand_bits(8)));
    emit_ext(sta_ext, 16'h3004);
    emit(suba_imm);
    emit(8'(rand_bits(8)));
    emit_ext(sta_ext, 16'h3005);
    emit(anda_imm);
    emit(8'(rand_bits(8)));
    emit_ext(sta_ext, 16'h3006);
    emit(addb_imm);
    emit(8'(rand_bits(8)));
    emit_ext(stb_ext, 16'h3007);
    // borrow decides whether the next five bytes run
    emit(lda_imm);
    emit(8'(rand_bits(8)));
    emit(suba_imm);
    emit(8'(rand_bits(8)));
    emit(bcs);
    emit(8'd5);
    emit(lda_imm);
    emit(8'h55);
    emit_ext(sta_ext, 16'h3008);
    emit_ext(sta_ext, 16'h3009);
    emit(addb_imm);
    emit(8'(rand_bits(8)));
    emit(bne);
    emit(8'd5);
    emit(ldb_imm);
    emit(8'haa);
    emit_ext(stb_ext, 16'h300a);
    emit_ext(stb_ext, 16'h300b);
    emit(nop);
    // two post-increment stores, then read the first one back
    emit(ldx_imm);
    emit(8'h30);
    emit(8'h10 | 8'(rand_bits(4)));
    emit(lda_imm);
    emit(8'(rand_bits(8)));
    emit(sta_idx);
    emit(8'h80 | off);
    emit(adda_imm);
    emit(8'h01);
    emit(sta_idx);
    emit(8'h80 | off);
    emit(lda_imm);
    emit(8'h00);
    emit(lda_idx);
    emit((off - 8'd2) & 8'h7f);
    emit_ext(sta_ext, 16'h3020);
    // end marker and a branch to itself
    emit_ext(sta_ext, 16'hffff);
    emit(bra);
    emit(8'hfe);
endfunction

// instruction-set model, lists the expected writes in order
function automatic void run_model();
    logic [15:0] pc;
    logic [15:0] x;
    logic [15:0] ea;
    logic [7:0]  opc;
    logic [7:0]  acc;
    logic [7:0]  arg;
    logic [7:0]  r;
    logic [8:0]  s;
    logic        z;
    logic        c;
    logic        is_b;
    logic        is_ext;
    logic        is_idx;
    logic        is_store;
    logic        done;
    pc   = RESET_PC;
    x    = '0;
    a_m  = '0;
    b_m  = '0;
    z    = 1'b0;
    c    = 1'b0;
    done = 1'b0;
    for (int k = 0; k < 1000 && !done; k++) begin
        opc      = ref_mem[pc];
        pc       = pc + 16'd1;
        is_b     = opc == ldb_imm || opc == ldb_ext || opc == stb_ext || opc == addb_imm;
        is_ext   = opc == lda_ext || opc == ldb_ext || opc == sta_ext || opc == stb_ext;
        is_idx   = opc == lda_idx || opc == sta_idx;
        is_store = opc == sta_ext || opc == stb_ext || opc == sta_idx;
        acc      = is_b ? b_m : a_m;
        case (opc)
            ldx_imm: begin
                x  = {ref_mem[pc], ref_mem[pc + 16'd1]};
                pc = pc + 16'd2;
            end
            bra, bne, bcs: begin
                arg = ref_mem[pc];
                pc  = pc + 16'd1;
                if (opc == bra || (opc == bne && !z) || (opc == bcs && c)) begin
                    pc = pc + {{8{arg[7]}}, arg};
                end
            end
            lda_imm, ldb_imm, adda_imm, suba_imm, anda_imm, addb_imm,
            lda_ext, ldb_ext, sta_ext, stb_ext, lda_idx, sta_idx: begin
                if (is_ext) begin
                    ea = {ref_mem[pc], ref_mem[pc + 16'd1]};
                    pc = pc + 16'd2;
                end else if (is_idx) begin
                    arg = ref_mem[pc];
                    pc  = pc + 16'd1;
                    ea  = x + {{9{arg[6]}}, arg[6:0]};
                    if (arg[7]) begin
                        x = x + 16'd1;
                    end
                end else begin
                    // immediate byte follows the opcode
                    ea = pc;
                    pc = pc + 16'd1;
                end
                if (is_store) begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(acc);
                    ref_mem[ea] = acc;
                    done        = ea == 16'hffff;
                    // a halted core parks on the next opcode
                    if (exp_addr.size() == HALT_AFTER) begin
                        halt_addr = pc;
                    end
                end else begin
                    arg = ref_mem[ea];
                    r   = arg;
                    if (opc == adda_imm || opc == addb_imm) begin
                        s = {1'b0, acc} + {1'b0, arg};
                        r = s[7:0];
                        c = s[8];
                    end else if (opc == suba_imm) begin
                        s = {1'b0, acc} - {1'b0, arg};
                        r = s[7:0];
                        c = s[8];
                    end else if (opc == anda_imm) begin
                        r = acc & arg;
                    end
                    z = r == 8'h00;
                    if (is_b) begin
                        b_m = r;
                    end else begin
                        a_m = r;
                    end
                end
            end
            default: begin
                // nop and unused codes do nothing
            end
        endcase
    end
endfunction

`endif

// File: sim/kcpu_tb.sv
`timescale 1ns/1ns

module kcpu_tb import kcpu_pkg::*; ();

    localparam logic [ADDR_W-1:0] RESET_PC = 16'h0100;
    localparam int TIMEOUT = 4000;
    localparam int HALT_AFTER = 6;

    logic              clk;
    logic              reset;
    logic              cen;
    logic              dtack;
    logic              halt;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] dout;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] mem [0:65535];
    logic [DATA_W-1:0] ref_mem [0:65535];
    logic [ADDR_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];
    logic [DATA_W-1:0] a_m;
    logic [DATA_W-1:0] b_m;
    logic [ADDR_W-1:0] halt_addr;
    logic [1:0]        cyc;
    int                n_writes;
    int                halt_span;

    `include "kcpu_tb_model.svh"

    kcpu #(.RESET_PC(RESET_PC)) uut (
        .clk   ( clk   ),
        .reset ( reset ),
        .cen   ( cen   ),
        .dtack ( dtack ),
        .halt  ( halt  ),
        .din   ( din   ),
        .addr  ( addr  ),
        .dout  ( dout  ),
        .we    ( we    )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory with combinational read
    assign din = mem[addr];

    always @(posedge clk) begin
        if (we && cen && dtack) begin
            mem[addr] <= dout;
        end
    end

    // cen three cycles in four, dtack random
    always @(posedge clk) begin
        #2;
        cyc   <= cyc + 2'd1;
        cen   <= cyc != 2'd3;
        dtack <= rand_bits(1) != 0;
    end

    task automatic stop_with_error(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic wait_writes(input int count);
        int cycles;
        cycles = 0;
        while (n_writes < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_with_error("timed out waiting for the next bus write");
            end
        end
    endtask

    // compare each write against the model list
    always @(negedge clk) begin
        if (reset) begin
            check_flag("we", we, 1'b0);
        end else if (we && cen && dtack) begin
            if (n_writes >= exp_addr.size()) begin
                stop_with_error("DUT wrote more often than the model expects");
            end else begin
                check_addr("addr", addr, exp_addr[n_writes]);
                check_data("dout", dout, exp_data[n_writes]);
                n_writes++;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        cen        = 1'b0;
        dtack      = 1'b0;
        halt       = 1'b0;
        cyc        = 2'd0;
        n_writes   = 0;
        lfsr_state = 32'hb0e8;
        for (int i = 0; i < 65536; i++) begin
            mem[i]     = i[7:0] ^ i[15:8] ^ 8'h3c;
            ref_mem[i] = mem[i];
        end
        build_program();
        halt_span = 16 + int'(rand_bits(6));
        run_model();
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_addr("addr", addr, RESET_PC);

        // halt right after a store completes, the core parks in fetch
        wait_writes(HALT_AFTER);
        #2;
        halt = 1'b1;
        repeat (halt_span) begin
            @(negedge clk);
            check_flag("we", we, 1'b0);
            check_addr("addr", addr, halt_addr);
        end
        @(posedge clk);
        #2;
        halt = 1'b0;

        wait_writes(exp_addr.size());
        // quiet period so a stray extra write is still caught
        repeat (20) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: design/kcpu.sv
`timescale 1ns/1ns

module kcpu import kcpu_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = 16'h0100
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic              dtack,
    input  logic              halt,
    input  logic [DATA_W-1:0] din,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] dout,
    output logic              we
);

    logic              step;
    opcode_t           op;
    logic [ADDR_W-1:0] opnd;
    logic [ADDR_W-1:0] ea;
    logic [ADDR_W-1:0] x;
    logic [ADDR_W-1:0] x_next;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] alu_rslt;
    ctrl_t             ctrl;
    cc_t               cc;
    cc_t               alu_cc;
    bus_t              bus;

    assign addr = bus.addr;
    assign dout = bus.dout;
    assign we   = bus.we;

    kcpu_memctrl #(.RESET_PC(RESET_PC)) u_memctrl (
        .clk     ( clk      ),
        .reset   ( reset    ),
        .cen     ( cen      ),
        .dtack   ( dtack    ),
        .din     ( din      ),
        .ctrl    ( ctrl     ),
        .ea      ( ea       ),
        .st_data ( acc      ),
        .step    ( step     ),
        .op      ( op       ),
        .opnd    ( opnd     ),
        .bus     ( bus      )
    );

    kcpu_ctrl u_ctrl (
        .clk     ( clk      ),
        .reset   ( reset    ),
        .step    ( step     ),
        .halt    ( halt     ),
        .op      ( op       ),
        .cc      ( cc       ),
        .ctrl    ( ctrl     )
    );

    kcpu_regs u_regs (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .step     ( step     ),
        .ctrl     ( ctrl     ),
        .din      ( din      ),
        .opnd     ( opnd     ),
        .alu_rslt ( alu_rslt ),
        .alu_cc   ( alu_cc   ),
        .x_next   ( x_next   ),
        .acc      ( acc      ),
        .x        ( x        ),
        .cc       ( cc       )
    );

    // second ALU operand is always the byte on the bus
    kcpu_alu u_alu (
        .alu_op  ( ctrl.alu_op ),
        .acc     ( acc         ),
        .arg     ( din         ),
        .cc_in   ( cc          ),
        .rslt    ( alu_rslt    ),
        .cc_out  ( alu_cc      )
    );

    kcpu_idx u_idx (
        .ctrl    ( ctrl     ),
        .opnd    ( opnd     ),
        .x       ( x        ),
        .ea      ( ea       ),
        .x_next  ( x_next   )
    );

endmodule

// File: design/kcpu_memctrl.sv
`timescale 1ns/1ns

module kcpu_memctrl import kcpu_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cen,
    input  logic              dtack,
    input  logic [DATA_W-1:0] din,
    input  ctrl_t             ctrl,
    input  logic [ADDR_W-1:0] ea,
    input  logic [DATA_W-1:0] st_data,
    output logic              step,
    output opcode_t           op,
    output logic [ADDR_W-1:0] opnd,
    output bus_t              bus
);

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] rel;
    opcode_t           op_q;

    // the core only moves when the bus acknowledges
    assign step = cen & dtack;

    // during fetch the sequencer decodes the byte still on the bus
    assign op = ctrl.ld_op ? opcode_t'(din) : op_q;

    // branch displacement, signed
    assign rel = {{(ADDR_W-DATA_W){din[DATA_W-1]}}, din};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= RESET_PC;
            op_q <= nop;
        end else if (step) begin
            if (ctrl.ld_op) begin
                op_q <= opcode_t'(din);
            end
            if (ctrl.up_pc) begin
                if (ctrl.ld_pc) begin
                    pc <= pc + 1'b1 + rel;
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    // operand bytes, high byte first
    always_ff @(posedge clk) begin
        if (step) begin
            if (ctrl.ld_opnd_hi) begin
                opnd[ADDR_W-1:DATA_W] <= din;
            end
            if (ctrl.ld_opnd_lo) begin
                opnd[DATA_W-1:0] <= din;
            end
        end
    end

    // bus drive comes from registered state only
    always_comb begin
        bus.addr = ctrl.addr_sel ? ea : pc;
        bus.dout = st_data;
        bus.we   = ctrl.wr;
    end

endmodule

// File: design/kcpu_ctrl.sv
`timescale 1ns/1ns

module kcpu_ctrl import kcpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    step,
    input  logic    halt,
    input  opcode_t op,
    input  cc_t     cc,
    output ctrl_t   ctrl
);

    state_t state;
    state_t nx_state;

    // opcodes working on accumulator b
    function automatic logic uses_b(opcode_t o);
        return o == ldb_imm || o == ldb_ext || o == stb_ext || o == addb_imm;
    endfunction

    function automatic logic is_store(opcode_t o);
        return o == sta_ext || o == stb_ext || o == sta_idx;
    endfunction

    function automatic logic is_idx(opcode_t o);
        return o == lda_idx || o == sta_idx;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetch;
        end else if (step) begin
            state <= nx_state;
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = op;
        ctrl.sel_b  = uses_b(op);
        nx_state    = state;
        case (state)
            fetch: begin
                // halt holds the core here, nothing on the bus changes
                if (!halt) begin
                    ctrl.ld_op = 1'b1;
                    ctrl.up_pc = 1'b1;
                    case (op)
                        lda_imm, ldb_imm, adda_imm, suba_imm, anda_imm, addb_imm,
                        bra, bne, bcs:
                            nx_state = exec;
                        ldx_imm, lda_ext, ldb_ext, sta_ext, stb_ext:
                            nx_state = opnd_hi;
                        lda_idx, sta_idx:
                            nx_state = opnd_lo;
                        // nop and unknown codes
                        default:
                            nx_state = fetch;
                    endcase
                end
            end
            opnd_hi: begin
                ctrl.ld_opnd_hi = 1'b1;
                ctrl.up_pc      = 1'b1;
                nx_state        = opnd_lo;
            end
            opnd_lo: begin
                ctrl.ld_opnd_lo = 1'b1;
                ctrl.up_pc      = 1'b1;
                if (op == ldx_imm) begin
                    // low byte goes straight from the bus into x
                    ctrl.up_x = 1'b1;
                    nx_state  = fetch;
                end else if (is_store(op)) begin
                    nx_state = mem_wr;
                end else begin
                    nx_state = mem_rd;
                end
            end
            mem_rd: begin
                ctrl.addr_sel = 1'b1;
                ctrl.idx_mode = is_idx(op);
                ctrl.post_inc = is_idx(op);
                ctrl.up_x     = is_idx(op);
                ctrl.up_a     = !uses_b(op);
                ctrl.up_b     = uses_b(op);
                ctrl.up_cc    = 1'b1;
                nx_state      = fetch;
            end
            mem_wr: begin
                ctrl.addr_sel = 1'b1;
                ctrl.wr       = 1'b1;
                ctrl.idx_mode = is_idx(op);
                ctrl.post_inc = is_idx(op);
                ctrl.up_x     = is_idx(op);
                nx_state      = fetch;
            end
            exec: begin
                // immediate byte or branch offset sits at pc
                ctrl.up_pc = 1'b1;
                case (op)
                    bra:     ctrl.ld_pc = 1'b1;
                    bne:     ctrl.ld_pc = !cc.z;
                    bcs:     ctrl.ld_pc = cc.c;
                    default: begin
                        ctrl.up_a  = !uses_b(op);
                        ctrl.up_b  = uses_b(op);
                        ctrl.up_cc = 1'b1;
                    end
                endcase
                nx_state = fetch;
            end
            default: nx_state = fetch;
        endcase
    end

endmodule

// File: design/kcpu_regs.sv
`timescale 1ns/1ns

module kcpu_regs import kcpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              step,
    input  ctrl_t             ctrl,
    input  logic [DATA_W-1:0] din,
    input  logic [ADDR_W-1:0] opnd,
    input  logic [DATA_W-1:0] alu_rslt,
    input  cc_t               alu_cc,
    input  logic [ADDR_W-1:0] x_next,
    output logic [DATA_W-1:0] acc,
    output logic [ADDR_W-1:0] x,
    output cc_t               cc
);

    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;

    // one accumulator feeds both the ALU and the store data
    assign acc = ctrl.sel_b ? b : a;

    always_ff @(posedge clk) begin
        if (reset) begin
            a  <= '0;
            b  <= '0;
            x  <= '0;
            cc <= '0;
        end else if (step) begin
            // loads come through the ALU as a pass op
            if (ctrl.up_a) begin
                a <= alu_rslt;
            end
            if (ctrl.up_b) begin
                b <= alu_rslt;
            end
            if (ctrl.up_cc) begin
                cc <= alu_cc;
            end
            // post-increment in indexed mode, otherwise ldx immediate
            if (ctrl.up_x) begin
                if (ctrl.idx_mode) begin
                    x <= x_next;
                end else begin
                    x <= {opnd[ADDR_W-1:DATA_W], din};
                end
            end
        end
    end

endmodule

// File: design/kcpu_idx.sv
`timescale 1ns/1ns

module kcpu_idx import kcpu_pkg::*; (
    input  ctrl_t             ctrl,
    input  logic [ADDR_W-1:0] opnd,
    input  logic [ADDR_W-1:0] x,
    output logic [ADDR_W-1:0] ea,
    output logic [ADDR_W-1:0] x_next
);

    logic [ADDR_W-1:0] offset;
    logic              inc;

    // offset byte is bit 7 post-inc flag, bits 6..0 signed
    assign offset = {{(ADDR_W-7){opnd[6]}}, opnd[6:0]};
    assign inc    = ctrl.post_inc && opnd[7];

    // extended mode uses the full 16-bit operand
    assign ea = ctrl.idx_mode ? x + offset : opnd;

    // x moves after the access, so ea still sees the old value
    assign x_next = inc ? x + 1'b1 : x;

endmodule

// File: design/kcpu_alu.sv
`timescale 1ns/1ns

module kcpu_alu import kcpu_pkg::*; (
    input  opcode_t           alu_op,
    input  logic [DATA_W-1:0] acc,
    input  logic [DATA_W-1:0] arg,
    input  cc_t               cc_in,
    output logic [DATA_W-1:0] rslt,
    output cc_t               cc_out
);

    logic [DATA_W:0] sum;

    always_comb begin
        sum      = '0;
        rslt     = arg;
        cc_out   = cc_in;
        cc_out.v = 1'b0;
        case (alu_op)
            adda_imm, addb_imm: begin
                sum      = {1'b0, acc} + {1'b0, arg};
                rslt     = sum[DATA_W-1:0];
                cc_out.c = sum[DATA_W];
                // same signs in, different sign out
                cc_out.v = (acc[DATA_W-1] == arg[DATA_W-1]) &&
                           (rslt[DATA_W-1] != acc[DATA_W-1]);
            end
            suba_imm: begin
                sum      = {1'b0, acc} - {1'b0, arg};
                rslt     = sum[DATA_W-1:0];
                // carry is the borrow
                cc_out.c = sum[DATA_W];
                cc_out.v = (acc[DATA_W-1] != arg[DATA_W-1]) &&
                           (rslt[DATA_W-1] != acc[DATA_W-1]);
            end
            anda_imm: begin
                rslt = acc & arg;
            end
            // loads pass the bus byte
            default: begin
                rslt = arg;
            end
        endcase
        cc_out.z = rslt == '0;
        cc_out.n = rslt[DATA_W-1];
    end

endmodule

// File: design/kcpu_pkg.sv
package kcpu_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // 6809-style encodings for the supported subset
    typedef enum logic [7:0] {
        nop      = 8'h12,
        bra      = 8'h20,
        bcs      = 8'h25,
        bne      = 8'h26,
        suba_imm = 8'h80,
        anda_imm = 8'h84,
        lda_imm  = 8'h86,
        adda_imm = 8'h8b,
        ldx_imm  = 8'h8e,
        lda_idx  = 8'ha6,
        sta_idx  = 8'ha7,
        lda_ext  = 8'hb6,
        sta_ext  = 8'hb7,
        ldb_imm  = 8'hc6,
        addb_imm = 8'hcb,
        ldb_ext  = 8'hf6,
        stb_ext  = 8'hf7
    } opcode_t;

    typedef enum logic [2:0] {
        fetch,
        opnd_hi,
        opnd_lo,
        mem_rd,
        mem_wr,
        exec
    } state_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } cc_t;

    typedef struct packed {
        logic    up_a;
        logic    up_b;
        logic    up_x;
        logic    up_cc;
        opcode_t alu_op;
        logic    sel_b;
        // 0 selects pc, 1 the effective address
        logic    addr_sel;
        logic    wr;
        logic    ld_op;
        logic    ld_opnd_hi;
        logic    ld_opnd_lo;
        logic    up_pc;
        logic    ld_pc;
        logic    idx_mode;
        logic    post_inc;
    } ctrl_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] dout;
        logic              we;
    } bus_t;

endpackage
